// File: design/ntm_cosh_cfg_pkg.sv
// Register map and control encodings for the cosh accelerator
// APB byte addresses are 8 bits, data words 32 bits
// Matrix dimensions are 3 bits, legal range 1..MAX_DIM
`default_nettype none

package ntm_cosh_cfg_pkg;

  localparam int ADDR_W = 8;
  localparam int WORD_W = 32;
  localparam int DIM_W  = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [DIM_W-1:0]  dim_t;

  // Register offsets
  localparam addr_t ADDR_CTRL   = 8'h00;
  localparam addr_t ADDR_STATUS = 8'h04;
  localparam addr_t ADDR_SIZE   = 8'h08;
  localparam addr_t DATA_BASE   = 8'h80;

  // Field positions
  localparam int SIZE_J_LSB      = 0;
  localparam int SIZE_I_LSB      = 8;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // CTRL opcodes
  // Any other value written to CTRL is ignored
  typedef enum logic [WORD_W-1:0] {
    CMD_START_COSH = 32'd1,
    CMD_CLEAR_DONE = 32'd2
  } cmd_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_COMPUTE,
    ST_STORE
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/ntm_cosh_math_pkg.sv
// Unsigned Q4.12 arithmetic for the cosh series
// Range 0 .. 15.9998, no sign bit
// Taylor coefficients rounded to Q4.12: 1, 1/2, 1/24, 1/720
`default_nettype none

package ntm_cosh_math_pkg;

  localparam int Q_W       = 16;
  localparam int FRAC_BITS = 12;

  typedef logic [Q_W-1:0] q_t;

  // Saturation ceiling
  localparam q_t Q_MAX = '1;

  // Horner coefficients with C0 applied last
  localparam q_t COSH_C0 = 16'd4096;
  localparam q_t COSH_C1 = 16'd2048;
  localparam q_t COSH_C2 = 16'd171;
  localparam q_t COSH_C3 = 16'd6;

  // Series unit sequencing
  typedef enum logic [1:0] {
    SU_IDLE,
    SU_SQUARE,
    SU_HORNER,
    SU_DONE
  } series_state_e;

endpackage

`default_nettype wire

// File: design/ntm_cosh_if.sv
// One element job between matrix control and series unit
// start and done are single-cycle pulses, no overlap of jobs
`timescale 1ns/100ps
`default_nettype none

interface ntm_cosh_if
  import ntm_cosh_math_pkg::*;
();

  // Job request
  logic start;
  q_t   operand;

  // Job completion
  q_t   result;
  logic done;

  modport ctrl (output start, output operand, input result, input done);

  modport unit (input start, input operand, output result, output done);

endinterface

`default_nettype wire

// File: design/ntm_cosh_apb_regs.sv
// APB slave without wait states, PREADY not provided
// PRDATA and PSLVERR only meaningful in the access phase
// Buffer read launched in setup phase, data ready one cycle later
// DATA accesses refused while the engine runs
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_apb_regs
  import ntm_cosh_cfg_pkg::*;
  import ntm_cosh_math_pkg::*;
#(
  parameter int MAX_DIM = 4,
  parameter int IDX_W   = $clog2(MAX_DIM * MAX_DIM)
) (
  input  wire logic              CLK,
  input  wire logic              RST,
  input  wire logic              PSEL,
  input  wire logic              PENABLE,
  input  wire logic              PWRITE,
  input  wire addr_t             PADDR,
  input  wire word_t             PWDATA,
  output word_t                  PRDATA,
  output logic                   PSLVERR,
  input  wire logic              busy,
  input  wire logic              done,
  output logic                   cmd_start,
  output logic                   cmd_clear,
  output dim_t                   size_i,
  output dim_t                   size_j,
  output logic [IDX_W-1:0]       host_addr,
  output logic                   host_wr,
  output q_t                     host_wdata,
  input  wire q_t                host_rdata
);

  localparam int DEPTH = MAX_DIM * MAX_DIM;

  logic  access;
  logic  is_ctrl, is_status, is_size, is_data;
  addr_t data_off;
  logic  [ADDR_W-3:0] data_idx;
  logic  idx_ok;
  dim_t  wr_i, wr_j;
  logic  size_ok;
  cmd_e  cmd;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign access    = PSEL && PENABLE;
  assign is_ctrl   = (PADDR == ADDR_CTRL);
  assign is_status = (PADDR == ADDR_STATUS);
  assign is_size   = (PADDR == ADDR_SIZE);
  assign is_data   = (PADDR >= DATA_BASE);

  // Row-major word index into the buffer
  assign data_off = PADDR - DATA_BASE;
  assign data_idx = data_off[ADDR_W-1:2];
  assign idx_ok   = (data_idx < DEPTH);

  // Host port address held stable across setup and access
  assign host_addr  = data_idx[IDX_W-1:0];
  assign host_wdata = PWDATA[Q_W-1:0];
  assign host_wr    = access && PWRITE && is_data && !busy && idx_ok;

  // Commands fire in the access cycle only
  assign cmd = cmd_e'(PWDATA);
  always_comb begin
    cmd_start = 1'b0;
    cmd_clear = 1'b0;
    if (access && PWRITE && is_ctrl) begin
      case (cmd)
        CMD_START_COSH: cmd_start = 1'b1;
        CMD_CLEAR_DONE: cmd_clear = 1'b1;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // SIZE register with range check
  //////////////////////////////////////////////////

  assign wr_i    = PWDATA[SIZE_I_LSB +: DIM_W];
  assign wr_j    = PWDATA[SIZE_J_LSB +: DIM_W];
  assign size_ok = (wr_i != '0) && (wr_i <= MAX_DIM) && (wr_j != '0) && (wr_j <= MAX_DIM);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // 1x1 after reset
      size_i <= dim_t'(1);
      size_j <= dim_t'(1);
    end else if (access && PWRITE && is_size && size_ok) begin
      size_i <= wr_i;
      size_j <= wr_j;
    end
  end

  // Error response
  assign PSLVERR = access && ((is_data && (busy || !idx_ok)) ||
                              (PWRITE && is_size && !size_ok));

  // Read mux
  always_comb begin
    PRDATA = '0;
    if (is_status) begin
      PRDATA[STATUS_BUSY_BIT] = busy;
      PRDATA[STATUS_DONE_BIT] = done;
    end else if (is_size) begin
      PRDATA[SIZE_I_LSB +: DIM_W] = size_i;
      PRDATA[SIZE_J_LSB +: DIM_W] = size_j;
    end else if (is_data && !busy && idx_ok) begin
      PRDATA[Q_W-1:0] = host_rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/ntm_cosh_matrix_ctrl.sv
// Row and column walk over the matrix, one element at a time
// 7 cycles per element: fetch, 5 in series unit, store
// Size captured at start, later SIZE writes do not disturb a job
// Start while busy is ignored
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_matrix_ctrl
  import ntm_cosh_cfg_pkg::*;
  import ntm_cosh_math_pkg::*;
#(
  parameter int MAX_DIM = 4,
  parameter int IDX_W   = $clog2(MAX_DIM * MAX_DIM)
) (
  input  wire logic        CLK,
  input  wire logic        RST,
  input  wire logic        cmd_start,
  input  wire logic        cmd_clear,
  input  wire dim_t        size_i,
  input  wire dim_t        size_j,
  output logic             busy,
  output logic             done,
  output logic [IDX_W-1:0] eng_addr,
  output logic             eng_wr,
  output q_t               eng_wdata,
  input  wire q_t          eng_rdata,
  ntm_cosh_if.ctrl         cosh_job
);

  ctrl_state_e state;
  dim_t        row, col;
  dim_t        last_i, last_j;
  logic        start_q;
  q_t          res_q;
  logic [2*DIM_W-1:0] lin_idx;

  // Linear element index, row-major
  assign lin_idx  = row * last_j + row + col;
  assign eng_addr = lin_idx[IDX_W-1:0];

  assign busy      = (state != ST_IDLE);
  assign eng_wr    = (state == ST_STORE);
  assign eng_wdata = res_q;

  // Operand straight from the synchronous read of the fetch cycle
  assign cosh_job.start   = start_q;
  assign cosh_job.operand = eng_rdata;

  //////////////////////////////////////////////////
  // Element loop FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ST_IDLE;
      row     <= '0;
      col     <= '0;
      last_i  <= '0;
      last_j  <= '0;
      start_q <= 1'b0;
      done    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_start) begin
            row    <= '0;
            col    <= '0;
            last_i <= size_i - 1'b1;
            last_j <= size_j - 1'b1;
            done   <= 1'b0;
            state  <= ST_FETCH;
          end else if (cmd_clear) begin
            done <= 1'b0;
          end
        end
        ST_FETCH: begin
          // Read data lands next cycle together with the job start
          start_q <= 1'b1;
          state   <= ST_COMPUTE;
        end
        ST_COMPUTE: begin
          if (cosh_job.done) begin
            state <= ST_STORE;
          end
        end
        ST_STORE: begin
          // Column first, row on column wrap
          if (col == last_j) begin
            col <= '0;
            if (row == last_i) begin
              done  <= 1'b1;
              state <= ST_IDLE;
            end else begin
              row   <= row + 1'b1;
              state <= ST_FETCH;
            end
          end else begin
            col   <= col + 1'b1;
            state <= ST_FETCH;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Result holding register for the store cycle
  always_ff @(posedge CLK) begin
    if (state == ST_COMPUTE && cosh_job.done) begin
      res_q <= cosh_job.result;
    end
  end

endmodule

`default_nettype wire

// File: design/ntm_cosh_matrix_buffer.sv
// Element store, MAX_DIM squared Q4.12 words, no reset on contents
// Two synchronous read ports, one cycle latency each
// No port collision check, host access only while the engine is idle
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_matrix_buffer
  import ntm_cosh_math_pkg::*;
#(
  parameter int MAX_DIM = 4,
  parameter int IDX_W   = $clog2(MAX_DIM * MAX_DIM)
) (
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire logic [IDX_W-1:0] host_addr,
  input  wire logic             host_wr,
  input  wire q_t               host_wdata,
  output q_t                    host_rdata,
  input  wire logic [IDX_W-1:0] eng_addr,
  input  wire logic             eng_wr,
  input  wire q_t               eng_wdata,
  output q_t                    eng_rdata
);

  localparam int DEPTH = MAX_DIM * MAX_DIM;

  q_t mem [DEPTH];

  // Write ports
  always_ff @(posedge CLK) begin
    if (host_wr) begin
      mem[host_addr] <= host_wdata;
    end
    if (eng_wr) begin
      mem[eng_addr] <= eng_wdata;
    end
  end

  // Registered reads
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      host_rdata <= '0;
      eng_rdata  <= '0;
    end else begin
      host_rdata <= mem[host_addr];
      eng_rdata  <= mem[eng_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/ntm_cosh_series_unit.sv
// cosh(x) = 1 + y/2 + y^2/24 + y^3/720 with y = x*x, Horner order
// Every product truncated to Q4.12, sums and products saturate at Q_MAX
// Fixed 5 cycle job: start, square, three Horner steps, done on the last
// One shared multiplier
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_series_unit
  import ntm_cosh_math_pkg::*;
(
  input  wire logic CLK,
  input  wire logic RST,
  ntm_cosh_if.unit  cosh_job
);

  series_state_e state;
  logic          step;
  q_t            x_q;
  q_t            y_q;
  q_t            acc;

  q_t              mul_a, mul_b;
  logic [2*Q_W-1:0] prod;
  q_t              prod_q;
  q_t              coef;
  logic [Q_W:0]    sum;
  q_t              horner;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Square in SU_SQUARE, y times accumulator otherwise
  assign mul_a = (state == SU_SQUARE) ? x_q : y_q;
  assign mul_b = (state == SU_SQUARE) ? x_q : acc;
  assign prod  = mul_a * mul_b;

  // Truncate fraction, clamp integer overflow
  assign prod_q = (|prod[2*Q_W-1:FRAC_BITS+Q_W]) ? Q_MAX : prod[FRAC_BITS +: Q_W];

  // Coefficient per Horner step
  always_comb begin
    case (state)
      SU_HORNER: coef = step ? COSH_C1 : COSH_C2;
      SU_DONE:   coef = COSH_C0;
      default:   coef = COSH_C3;
    endcase
  end

  assign sum    = {1'b0, prod_q} + {1'b0, coef};
  assign horner = sum[Q_W] ? Q_MAX : sum[Q_W-1:0];

  // Final step result is valid with done
  assign cosh_job.result = horner;
  assign cosh_job.done   = (state == SU_DONE);

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= SU_IDLE;
      step  <= 1'b0;
    end else begin
      case (state)
        SU_IDLE:   if (cosh_job.start) state <= SU_SQUARE;
        SU_SQUARE: begin
          step  <= 1'b0;
          state <= SU_HORNER;
        end
        SU_HORNER: begin
          step <= 1'b1;
          if (step) state <= SU_DONE;
        end
        default:   state <= SU_IDLE;
      endcase
    end
  end

  // Operand, square and accumulator
  always_ff @(posedge CLK) begin
    if (state == SU_IDLE && cosh_job.start) x_q <= cosh_job.operand;
    if (state == SU_SQUARE) begin
      y_q <= prod_q;
      acc <= COSH_C3;
    end
    if (state == SU_HORNER) acc <= horner;
  end

endmodule

`default_nettype wire

// File: design/ntm_cosh_top.sv
// APB cosh accelerator, plain APB slave ports
// No PREADY and no interrupt, host polls STATUS or the done pin
// MAX_DIM legal range 2..5
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_top
  import ntm_cosh_cfg_pkg::*;
  import ntm_cosh_math_pkg::*;
#(
  parameter int MAX_DIM = 4
) (
  input  wire logic  CLK,
  input  wire logic  RST,
  input  wire logic  PSEL,
  input  wire logic  PENABLE,
  input  wire logic  PWRITE,
  input  wire addr_t PADDR,
  input  wire word_t PWDATA,
  output word_t      PRDATA,
  output logic       PSLVERR,
  output logic       done
);

  localparam int IDX_W = $clog2(MAX_DIM * MAX_DIM);

  // Register block to engine
  logic cmd_start, cmd_clear, busy;
  dim_t size_i, size_j;

  // Buffer ports
  logic [IDX_W-1:0] host_addr, eng_addr;
  logic             host_wr, eng_wr;
  q_t               host_wdata, host_rdata, eng_wdata, eng_rdata;

  ntm_cosh_if cosh_job ();

  ntm_cosh_apb_regs #(.MAX_DIM(MAX_DIM), .IDX_W(IDX_W)) apb_regs_i (
    .CLK, .RST, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PSLVERR,
    .busy, .done, .cmd_start, .cmd_clear, .size_i, .size_j,
    .host_addr, .host_wr, .host_wdata, .host_rdata
  );

  ntm_cosh_matrix_ctrl #(.MAX_DIM(MAX_DIM), .IDX_W(IDX_W)) matrix_ctrl_i (
    .CLK, .RST, .cmd_start, .cmd_clear, .size_i, .size_j, .busy, .done,
    .eng_addr, .eng_wr, .eng_wdata, .eng_rdata, .cosh_job(cosh_job.ctrl)
  );

  ntm_cosh_matrix_buffer #(.MAX_DIM(MAX_DIM), .IDX_W(IDX_W)) matrix_buffer_i (
    .CLK, .RST, .host_addr, .host_wr, .host_wdata, .host_rdata,
    .eng_addr, .eng_wr, .eng_wdata, .eng_rdata
  );

  ntm_cosh_series_unit series_unit_i (
    .CLK, .RST, .cosh_job(cosh_job.unit)
  );

endmodule

`default_nettype wire

// File: verif/ntm_cosh_assertions.sv
// Protocol and control rules checked on the accelerator top level
// Bound into ntm_cosh_top, sampled on the rising clock edge
// fail_count tracks failed assertions for the testbench
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_assertions (
  input wire logic CLK,
  input wire logic RST,
  input wire logic PSEL,
  input wire logic PENABLE,
  input wire logic PSLVERR,
  input wire logic busy,
  input wire logic done,
  input wire logic job_done
);

  int fail_count = 0;

  // Error response only in the APB access phase
  slverr_in_access: assert property (@(posedge CLK) disable iff (RST)
    PSLVERR |-> (PSEL && PENABLE))
    else begin
      fail_count++;
      $error("PSLVERR raised outside an APB access phase");
    end

  // Engine is either running or finished, never both
  busy_done_exclusive: assert property (@(posedge CLK) disable iff (RST)
    !(busy && done))
    else begin
      fail_count++;
      $error("busy and done high in the same cycle");
    end

  // Series unit completes only inside a running job
  job_done_while_busy: assert property (@(posedge CLK) disable iff (RST)
    job_done |-> busy)
    else begin
      fail_count++;
      $error("series unit done pulse while the engine is idle");
    end

endmodule

`default_nettype wire

// File: verif/ntm_cosh_tb.sv
// Table-driven APB testbench for the cosh accelerator, MAX_DIM fixed at 4
// Inputs driven 10 ns after the rising edge, outputs sampled at the falling edge
// Random elements from xorshift32, seed 3310, limited to [0, 2)
// Stops at the first error, run bounded by a cycle limit
`timescale 1ns/100ps
`default_nettype none

module ntm_cosh_tb
  import ntm_cosh_cfg_pkg::*;
  import ntm_cosh_math_pkg::*;
();

  localparam int  MAX_DIM   = 4;
  localparam int  DEPTH     = MAX_DIM * MAX_DIM;
  localparam time DRIVE_DLY = 10ns;
  localparam int  N_CASES   = 6;

  typedef struct {
    int size_i;
    int size_j;
    bit rand_data;
    bit exp_err;
  } case_t;

  // Size, data mode, expected SIZE error
  case_t cases [N_CASES] = '{
    '{2, 3, 1'b0, 1'b0},
    '{0, 3, 1'b0, 1'b1},
    '{2, MAX_DIM + 1, 1'b0, 1'b1},
    '{MAX_DIM, MAX_DIM, 1'b1, 1'b0},
    '{MAX_DIM, MAX_DIM, 1'b1, 1'b0},
    '{MAX_DIM, MAX_DIM, 1'b1, 1'b0}
  };

  // 0, 0.5, 1.0, 1.5, 1.75, 1.999 in Q4.12
  q_t fixed_data [6] = '{16'd0, 16'd2048, 16'd4096, 16'd6144, 16'd7168, 16'd8188};

  logic  CLK = 1'b0;
  logic  RST;
  logic  PSEL;
  logic  PENABLE;
  logic  PWRITE;
  addr_t PADDR;
  word_t PWDATA;
  word_t PRDATA;
  logic  PSLVERR;
  logic  done;

  int          cycle_count = 0;
  int          cycle_limit;
  int          last_access_cycle;
  int          done_cycle;
  logic        done_prev = 1'b0;
  logic [31:0] rng_state = 32'd3310;
  dim_t        cur_i = 3'd1;
  dim_t        cur_j = 3'd1;

  ntm_cosh_top #(.MAX_DIM(MAX_DIM)) ntm_cosh_top_i (
    .CLK, .RST, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PSLVERR, .done
  );

  bind ntm_cosh_top ntm_cosh_assertions assertions_i (
    .CLK(CLK), .RST(RST), .PSEL(PSEL), .PENABLE(PENABLE), .PSLVERR(PSLVERR),
    .busy(busy), .done(done), .job_done(cosh_job.done)
  );

  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Cycle counter, timeout, assertion watch
  //////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count++;
    if (ntm_cosh_top_i.assertions_i.fail_count != 0) begin
      $display("A bound assertion failed at %0t", $time);
      $display("CHECKS FAILED");
      $fatal(1, "assertion failure");
    end else if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Cycle in which the done port rose
  always @(negedge CLK) begin
    if (done && !done_prev) done_cycle = cycle_count;
    done_prev = done;
  end

  //////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////

  function automatic int compute_limit();
    int total;
    int n;
    total = 0;
    foreach (cases[c]) begin
      n = cases[c].size_i * cases[c].size_j;
      total += 7 * n + 40 * n + 20;
    end
    return 2 * total;
  endfunction

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  function automatic addr_t data_addr(input int k);
    return addr_t'(DATA_BASE + 4 * k);
  endfunction

  function automatic q_t clamp_q(input longint unsigned v);
    return (v > 64'hFFFF) ? 16'hFFFF : q_t'(v);
  endfunction

  // 1 + y/2 + y^2/24 + y^3/720, Horner, products truncated by 12 bits
  function automatic q_t cosh_model(input q_t x);
    longint unsigned xl;
    longint unsigned y;
    longint unsigned acc;
    xl  = x;
    y   = clamp_q((xl * xl) >> 12);
    acc = clamp_q(((y * 6) >> 12) + 171);
    acc = clamp_q(((y * acc) >> 12) + 2048);
    return clamp_q(((y * acc) >> 12) + 4096);
  endfunction

  task automatic check_q(input string name, input q_t got, input q_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "first error");
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "first error");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "first error");
    end
  endtask

  //////////////////////////////////////////////////
  // APB transfers, two cycles each
  //////////////////////////////////////////////////

  task automatic apb_write(input addr_t addr, input word_t data, output logic err);
    @(posedge CLK);
    #DRIVE_DLY;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    @(posedge CLK);
    #DRIVE_DLY;
    PENABLE = 1'b1;
    @(negedge CLK);
    err = PSLVERR;
    last_access_cycle = cycle_count;
    @(posedge CLK);
    #DRIVE_DLY;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic apb_read(input addr_t addr, output word_t data, output logic err);
    @(posedge CLK);
    #DRIVE_DLY;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = addr;
    @(posedge CLK);
    #DRIVE_DLY;
    PENABLE = 1'b1;
    @(negedge CLK);
    data = PRDATA;
    err  = PSLVERR;
    @(posedge CLK);
    #DRIVE_DLY;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // One matrix job
  //////////////////////////////////////////////////

  task automatic run_job(input int si, input int sj, input bit rand_data);
    int    n;
    int    polls;
    int    start_cycle;
    logic  err;
    logic  finished;
    word_t rd;
    q_t    x;
    q_t    x_in [$];
    n = si * sj;
    // Load elements, row-major
    for (int k = 0; k < n; k++) begin
      if (rand_data) begin
        rng_state = next_random(rng_state);
        x = q_t'(rng_state[12:0]);
      end else begin
        x = fixed_data[k];
      end
      x_in.push_back(x);
      apb_write(data_addr(k), word_t'(x), err);
      check_flag("PSLVERR on DATA write", err, 1'b0);
    end
    apb_write(ADDR_CTRL, word_t'(CMD_START_COSH), err);
    start_cycle = last_access_cycle;
    check_flag("PSLVERR on start", err, 1'b0);
    apb_read(ADDR_STATUS, rd, err);
    check_word("STATUS while busy", rd, 32'h1);
    check_flag("done while busy", done, 1'b0);
    // Ignored restart, then refused buffer accesses
    apb_write(ADDR_CTRL, word_t'(CMD_START_COSH), err);
    apb_write(data_addr(n - 1), 32'h0000_7FFF, err);
    check_flag("PSLVERR on busy DATA write", err, 1'b1);
    apb_read(data_addr(0), rd, err);
    check_flag("PSLVERR on busy DATA read", err, 1'b1);
    finished = 1'b0;
    polls    = 0;
    while (!finished && polls < 7 * n + 1) begin
      apb_read(ADDR_STATUS, rd, err);
      finished = rd[STATUS_DONE_BIT];
      polls++;
    end
    if (!finished) begin
      $display("Error: done never rose for the %0dx%0d job", si, sj);
      $display("CHECKS FAILED");
      $fatal(1, "job did not finish");
    end
    check_word("STATUS after job", rd, 32'h2);
    check_flag("done after job", done, 1'b1);
    check_word("job latency", word_t'(done_cycle - start_cycle), word_t'(7 * n + 1));
    for (int k = 0; k < n; k++) begin
      apb_read(data_addr(k), rd, err);
      check_flag("PSLVERR on DATA read", err, 1'b0);
      // A zero input is checked against the exact value of one
      if (!rand_data && x_in[k] == 16'd0) begin
        check_q("cosh of zero", rd[Q_W-1:0], 16'd4096);
      end else begin
        check_q("DATA result", rd[Q_W-1:0], cosh_model(x_in[k]));
      end
    end
    // One past the last buffer entry
    apb_read(data_addr(DEPTH), rd, err);
    check_flag("PSLVERR on DATA index out of range", err, 1'b1);
    apb_write(ADDR_CTRL, word_t'(CMD_CLEAR_DONE), err);
    apb_read(ADDR_STATUS, rd, err);
    check_word("STATUS after clear", rd, 32'h0);
    check_flag("done after clear", done, 1'b0);
  endtask

  // SIZE write, readback, then the job if the size is legal
  task automatic run_case(input int c);
    logic  err;
    word_t rd;
    word_t size_word;
    size_word = word_t'((cases[c].size_i << SIZE_I_LSB) | (cases[c].size_j << SIZE_J_LSB));
    apb_write(ADDR_SIZE, size_word, err);
    check_flag("PSLVERR on SIZE write", err, cases[c].exp_err);
    if (!cases[c].exp_err) begin
      cur_i = dim_t'(cases[c].size_i);
      cur_j = dim_t'(cases[c].size_j);
    end
    apb_read(ADDR_SIZE, rd, err);
    check_word("SIZE", rd, (word_t'(cur_i) << SIZE_I_LSB) | (word_t'(cur_j) << SIZE_J_LSB));
    if (!cases[c].exp_err) run_job(cases[c].size_i, cases[c].size_j, cases[c].rand_data);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    RST     = 1'b1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    cycle_limit = compute_limit();
    repeat (5) @(posedge CLK);
    #DRIVE_DLY;
    RST = 1'b0;
    check_flag("done after reset", done, 1'b0);
    check_flag("PSLVERR after reset", PSLVERR, 1'b0);
    for (int c = 0; c < N_CASES; c++) begin
      run_case(c);
    end
    if (ntm_cosh_top_i.assertions_i.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ntm_cosh.f
design/ntm_cosh_cfg_pkg.sv
design/ntm_cosh_math_pkg.sv
design/ntm_cosh_if.sv
design/ntm_cosh_apb_regs.sv
design/ntm_cosh_matrix_ctrl.sv
design/ntm_cosh_matrix_buffer.sv
design/ntm_cosh_series_unit.sv
design/ntm_cosh_top.sv
verif/ntm_cosh_assertions.sv
verif/ntm_cosh_tb.sv
